// ==== verilog/ex_pkg.sv ====
package ex_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  alu_sel_t;
    typedef logic [2:0]  alu_op_t;
    typedef logic [2:0]  mem_len_t;          // Access size in bytes

    // Unit selectors
    localparam alu_sel_t SEL_NOP   = 3'b000;
    localparam alu_sel_t SEL_LOGIC = 3'b001;
    localparam alu_sel_t SEL_SHIFT = 3'b010;
    localparam alu_sel_t SEL_ARITH = 3'b100;
    localparam alu_sel_t SEL_LINK  = 3'b110;
    localparam alu_sel_t SEL_MEM   = 3'b111;

    localparam mem_len_t LEN_BYTE = 3'd1;
    localparam mem_len_t LEN_HALF = 3'd2;
    localparam mem_len_t LEN_WORD = 3'd4;

endpackage

// ==== verilog/data_ram.sv ====
`timescale 1ns/1ns

module data_ram import ex_pkg::*; #(
    parameter int RAM_WORDS = 64
) (
    input  logic                         clk,
    input  logic                         we_i,
    input  logic [3:0]                   be_i,
    input  logic [$clog2(RAM_WORDS)-1:0] addr_i,
    input  word_t                        wdata_i,
    output word_t                        rdata_o
);

    word_t mem [RAM_WORDS];

    // Old data is returned when reading and writing the same word
    always_ff @(posedge clk) begin
        rdata_o <= mem[addr_i];
        if (we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (be_i[b]) begin
                    mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== verilog/issue_fifo.sv ====
`timescale 1ns/1ns

module issue_fifo import ex_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      push_i,
    input  logic      pop_i,
    input  alu_sel_t  alusel_i,
    input  alu_op_t   aluop_i,
    input  word_t     op1_i,
    input  word_t     op2_i,
    input  word_t     link_addr_i,
    input  logic      write_i,
    input  reg_addr_t regw_addr_i,
    input  word_t     mem_offset_i,
    output alu_sel_t  alusel_o,
    output alu_op_t   aluop_o,
    output word_t     op1_o,
    output word_t     op2_o,
    output word_t     link_addr_o,
    output logic      write_o,
    output reg_addr_t regw_addr_o,
    output word_t     mem_offset_o,
    output logic      empty_o,
    output logic      credit_o
);

    localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    alu_sel_t  alusel_q    [FIFO_DEPTH];
    alu_op_t   aluop_q     [FIFO_DEPTH];
    word_t     op1_q       [FIFO_DEPTH];
    word_t     op2_q       [FIFO_DEPTH];
    word_t     link_addr_q [FIFO_DEPTH];
    logic      write_q     [FIFO_DEPTH];
    reg_addr_t regw_addr_q [FIFO_DEPTH];
    word_t     mem_offset_q[FIFO_DEPTH];

    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_pop;

    function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] ptr);
        return (ptr == PW'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty_o = (count == '0);
    assign do_pop  = pop_i && !empty_o;   // Pop on empty is ignored

    assign alusel_o     = alusel_q[rd_ptr];
    assign aluop_o      = aluop_q[rd_ptr];
    assign op1_o        = op1_q[rd_ptr];
    assign op2_o        = op2_q[rd_ptr];
    assign link_addr_o  = link_addr_q[rd_ptr];
    assign write_o      = write_q[rd_ptr];
    assign regw_addr_o  = regw_addr_q[rd_ptr];
    assign mem_offset_o = mem_offset_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_i) begin
            alusel_q[wr_ptr]     <= alusel_i;
            aluop_q[wr_ptr]      <= aluop_i;
            op1_q[wr_ptr]        <= op1_i;
            op2_q[wr_ptr]        <= op2_i;
            link_addr_q[wr_ptr]  <= link_addr_i;
            write_q[wr_ptr]      <= write_i;
            regw_addr_q[wr_ptr]  <= regw_addr_i;
            mem_offset_q[wr_ptr] <= mem_offset_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            credit_o <= do_pop;           // One credit per released entry
            if (push_i) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({push_i, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== verilog/stage_ex.sv ====
`timescale 1ns/1ns

module stage_ex import ex_pkg::*; (
    input  alu_sel_t  alusel_i,
    input  alu_op_t   aluop_i,
    input  word_t     op1_i,
    input  word_t     op2_i,
    input  word_t     link_addr_i,
    input  logic      write_i,
    input  reg_addr_t regw_addr_i,
    input  word_t     mem_offset_i,
    output logic      write_o,
    output reg_addr_t regw_addr_o,
    output word_t     regw_data_o,
    output logic      load_o,
    output logic      store_o,
    output word_t     mem_write_data_o,
    output mem_len_t  mem_length_o,
    output logic      mem_signed_o
);

    word_t      logic_ret;
    word_t      shift_ret;
    word_t      arith_ret;
    word_t      mem_addr;
    logic [4:0] shamt;

    assign shamt    = op2_i[4:0];
    assign mem_addr = op1_i + mem_offset_i;   // Effective address

    always_comb begin
        case (aluop_i)
            3'd0:    logic_ret = op1_i | op2_i;
            3'd1:    logic_ret = op1_i & op2_i;
            3'd2:    logic_ret = op1_i ^ op2_i;
            default: logic_ret = '0;
        endcase
    end

    always_comb begin
        case (aluop_i)
            3'd0:    shift_ret = op1_i << shamt;
            3'd1:    shift_ret = op1_i >> shamt;
            3'd2:    shift_ret = word_t'($signed(op1_i) >>> shamt);
            default: shift_ret = '0;
        endcase
    end

    always_comb begin
        case (aluop_i)
            3'd0:    arith_ret = op1_i + op2_i;
            3'd1:    arith_ret = op1_i - op2_i;
            3'd2:    arith_ret = {31'b0, $signed(op1_i) < $signed(op2_i)};
            3'd3:    arith_ret = {31'b0, op1_i < op2_i};
            default: arith_ret = '0;
        endcase
    end

    // Load/store decode
    always_comb begin
        load_o           = 1'b0;
        store_o          = 1'b0;
        mem_length_o     = LEN_WORD;
        mem_signed_o     = 1'b0;
        mem_write_data_o = '0;
        if (alusel_i == SEL_MEM) begin
            case (aluop_i)
                3'd0: begin                       // LB
                    load_o       = 1'b1;
                    mem_length_o = LEN_BYTE;
                    mem_signed_o = 1'b1;
                end
                3'd1: begin                       // LH
                    load_o       = 1'b1;
                    mem_length_o = LEN_HALF;
                    mem_signed_o = 1'b1;
                end
                3'd2: begin                       // LW
                    load_o       = 1'b1;
                    mem_signed_o = 1'b1;
                end
                3'd3: begin                       // LBU
                    load_o       = 1'b1;
                    mem_length_o = LEN_BYTE;
                end
                3'd4: begin                       // LHU
                    load_o       = 1'b1;
                    mem_length_o = LEN_HALF;
                end
                3'd5: begin                       // SB
                    store_o          = 1'b1;
                    mem_length_o     = LEN_BYTE;
                    mem_write_data_o = op2_i;
                end
                3'd6: begin                       // SH
                    store_o          = 1'b1;
                    mem_length_o     = LEN_HALF;
                    mem_write_data_o = op2_i;
                end
                default: begin                    // SW
                    store_o          = 1'b1;
                    mem_write_data_o = op2_i;
                end
            endcase
        end
    end

    always_comb begin
        case (alusel_i)
            SEL_NOP:   regw_data_o = '0;
            SEL_LOGIC: regw_data_o = logic_ret;
            SEL_SHIFT: regw_data_o = shift_ret;
            SEL_ARITH: regw_data_o = arith_ret;
            SEL_LINK:  regw_data_o = link_addr_i;
            SEL_MEM:   regw_data_o = mem_addr;
            default:   regw_data_o = '0;       // Undefined selectors
        endcase
    end

    assign write_o     = write_i && !store_o;  // Stores never write back
    assign regw_addr_o = regw_addr_i;

endmodule

// ==== verilog/stage_mem.sv ====
`timescale 1ns/1ns

module stage_mem import ex_pkg::*; #(
    parameter int RAM_WORDS = 64
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      valid_i,
    input  logic      write_i,
    input  reg_addr_t regw_addr_i,
    input  word_t     regw_data_i,
    input  logic      load_i,
    input  logic      store_i,
    input  word_t     mem_write_data_i,
    input  mem_len_t  mem_length_i,
    input  logic      mem_signed_i,
    output logic      wb_valid_o,
    output logic      wb_write_o,
    output reg_addr_t wb_addr_o,
    output word_t     wb_data_o
);

    localparam int AW = $clog2(RAM_WORDS);

    logic [3:0]    be;
    word_t         lane_data;
    logic [AW-1:0] ram_addr;
    logic          ram_we;
    word_t         ram_rdata;

    logic          valid_q;
    logic          write_q;
    reg_addr_t     regw_addr_q;
    word_t         data_q;
    logic          load_q;
    mem_len_t      len_q;
    logic          signed_q;

    logic [7:0]    byte_sel;
    logic [15:0]   half_sel;
    word_t         load_data;

    assign ram_addr = regw_data_i[AW+1:2];    // Wraps at RAM size
    assign ram_we   = valid_i && store_i;

    // Byte enables and replicated store data
    always_comb begin
        case (mem_length_i)
            LEN_BYTE: begin
                be        = 4'b0001 << regw_data_i[1:0];
                lane_data = {4{mem_write_data_i[7:0]}};
            end
            LEN_HALF: begin
                be        = regw_data_i[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{mem_write_data_i[15:0]}};
            end
            default: begin
                be        = 4'b1111;
                lane_data = mem_write_data_i;
            end
        endcase
    end

    data_ram #(
        .RAM_WORDS(RAM_WORDS)
    ) ram_i (
        .clk    (clk),
        .we_i   (ram_we),
        .be_i   (be),
        .addr_i (ram_addr),
        .wdata_i(lane_data),
        .rdata_o(ram_rdata)
    );

    assign byte_sel = ram_rdata[{data_q[1:0], 3'b000} +: 8];
    assign half_sel = data_q[1] ? ram_rdata[31:16] : ram_rdata[15:0];

    always_comb begin
        case (len_q)
            LEN_BYTE: load_data = {{24{signed_q & byte_sel[7]}}, byte_sel};
            LEN_HALF: load_data = {{16{signed_q & half_sel[15]}}, half_sel};
            default:  load_data = ram_rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q    <= 1'b0;
            wb_valid_o <= 1'b0;
        end else begin
            valid_q    <= valid_i;
            wb_valid_o <= valid_q;
        end
    end

    always_ff @(posedge clk) begin
        write_q     <= write_i;
        regw_addr_q <= regw_addr_i;
        data_q      <= regw_data_i;
        load_q      <= load_i;
        len_q       <= mem_length_i;
        signed_q    <= mem_signed_i;
        wb_write_o  <= write_q;
        wb_addr_o   <= regw_addr_q;
        wb_data_o   <= load_q ? load_data : data_q;   // Stores keep the address
    end

endmodule

// ==== verilog/exec_unit.sv ====
`timescale 1ns/1ns

module exec_unit import ex_pkg::*; #(
    parameter int FIFO_DEPTH = 4,
    parameter int WB_CREDITS = 2,
    parameter int RAM_WORDS  = 64
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      issue_valid_i,
    input  alu_sel_t  alusel_i,
    input  alu_op_t   aluop_i,
    input  word_t     op1_i,
    input  word_t     op2_i,
    input  word_t     link_addr_i,
    input  logic      write_i,
    input  reg_addr_t regw_addr_i,
    input  word_t     mem_offset_i,
    output logic      issue_credit_o,
    input  logic      wb_credit_i,
    output logic      wb_valid_o,
    output logic      wb_write_o,
    output reg_addr_t wb_addr_o,
    output word_t     wb_data_o
);

    localparam int CW = $clog2(WB_CREDITS + 1);

    logic [CW-1:0] wb_credit_cnt;
    logic          pop;
    logic          fifo_empty;

    alu_sel_t      hd_alusel;
    alu_op_t       hd_aluop;
    word_t         hd_op1;
    word_t         hd_op2;
    word_t         hd_link_addr;
    logic          hd_write;
    reg_addr_t     hd_regw_addr;
    word_t         hd_mem_offset;

    logic          ex_write;
    reg_addr_t     ex_regw_addr;
    word_t         ex_regw_data;
    logic          ex_load;
    logic          ex_store;
    word_t         ex_mem_write_data;
    mem_len_t      ex_mem_length;
    logic          ex_mem_signed;

    assign pop = !fifo_empty && (wb_credit_cnt != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_credit_cnt <= CW'(WB_CREDITS);
        end else if (pop && !wb_credit_i) begin
            wb_credit_cnt <= wb_credit_cnt - 1'b1;
        end else if (!pop && wb_credit_i) begin
            wb_credit_cnt <= wb_credit_cnt + 1'b1;
        end
    end

    issue_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) fifo_i (
        .clk         (clk),
        .reset       (reset),
        .push_i      (issue_valid_i),
        .pop_i       (pop),
        .alusel_i    (alusel_i),
        .aluop_i     (aluop_i),
        .op1_i       (op1_i),
        .op2_i       (op2_i),
        .link_addr_i (link_addr_i),
        .write_i     (write_i),
        .regw_addr_i (regw_addr_i),
        .mem_offset_i(mem_offset_i),
        .alusel_o    (hd_alusel),
        .aluop_o     (hd_aluop),
        .op1_o       (hd_op1),
        .op2_o       (hd_op2),
        .link_addr_o (hd_link_addr),
        .write_o     (hd_write),
        .regw_addr_o (hd_regw_addr),
        .mem_offset_o(hd_mem_offset),
        .empty_o     (fifo_empty),
        .credit_o    (issue_credit_o)
    );

    stage_ex ex_i (
        .alusel_i        (hd_alusel),
        .aluop_i         (hd_aluop),
        .op1_i           (hd_op1),
        .op2_i           (hd_op2),
        .link_addr_i     (hd_link_addr),
        .write_i         (hd_write),
        .regw_addr_i     (hd_regw_addr),
        .mem_offset_i    (hd_mem_offset),
        .write_o         (ex_write),
        .regw_addr_o     (ex_regw_addr),
        .regw_data_o     (ex_regw_data),
        .load_o          (ex_load),
        .store_o         (ex_store),
        .mem_write_data_o(ex_mem_write_data),
        .mem_length_o    (ex_mem_length),
        .mem_signed_o    (ex_mem_signed)
    );

    stage_mem #(
        .RAM_WORDS(RAM_WORDS)
    ) mem_i (
        .clk             (clk),
        .reset           (reset),
        .valid_i         (pop),
        .write_i         (ex_write),
        .regw_addr_i     (ex_regw_addr),
        .regw_data_i     (ex_regw_data),
        .load_i          (ex_load),
        .store_i         (ex_store),
        .mem_write_data_i(ex_mem_write_data),
        .mem_length_i    (ex_mem_length),
        .mem_signed_i    (ex_mem_signed),
        .wb_valid_o      (wb_valid_o),
        .wb_write_o      (wb_write_o),
        .wb_addr_o       (wb_addr_o),
        .wb_data_o       (wb_data_o)
    );

endmodule

// ==== testbench/exec_unit_checker.sv ====
`timescale 1ns/1ns

module exec_unit_checker #(
    parameter int FIFO_DEPTH = 4,
    parameter int WB_CREDITS = 2
) (
    input logic                                clk,
    input logic                                reset,
    input logic                                issue_valid_i,
    input logic                                pop_i,
    input logic [$clog2(WB_CREDITS + 1)-1:0]   credit_cnt_i,
    input logic                                issue_credit_i,
    input logic                                wb_valid_i
);

    int          occupancy;
    logic        reset_seen = 1'b0;
    int unsigned fail_count = 0;

    always_ff @(posedge clk) begin
        if (reset) begin
            occupancy  <= 0;
            reset_seen <= 1'b1;
        end else begin
            occupancy <= occupancy + int'(issue_valid_i) - int'(pop_i);
        end
    end

    no_overflow: assert property (@(posedge clk) disable iff (reset)
        occupancy <= FIFO_DEPTH)
        else begin
            $error("issue queue overflow, %0d entries", occupancy);
            fail_count++;
        end

    credit_limit: assert property (@(posedge clk) disable iff (reset)
        credit_cnt_i <= WB_CREDITS)
        else begin
            $error("write-back credit counter above limit");
            fail_count++;
        end

    pop_to_valid: assert property (@(posedge clk) disable iff (reset)
        pop_i |-> ##2 wb_valid_i)
        else begin
            $error("pop without write-back two cycles later");
            fail_count++;
        end

    valid_from_pop: assert property (@(posedge clk) disable iff (reset)
        wb_valid_i |-> $past(pop_i, 2))
        else begin
            $error("write-back without a pop two cycles before");
            fail_count++;
        end

    quiet_in_reset: assert property (@(posedge clk)
        (reset && reset_seen) |-> (!issue_credit_i && !wb_valid_i))
        else begin
            $error("control output high during reset");
            fail_count++;
        end

endmodule

bind exec_unit exec_unit_checker #(
    .FIFO_DEPTH(FIFO_DEPTH),
    .WB_CREDITS(WB_CREDITS)
) exec_checker_i (
    .clk           (clk),
    .reset         (reset),
    .issue_valid_i (issue_valid_i),
    .pop_i         (pop),
    .credit_cnt_i  (wb_credit_cnt),
    .issue_credit_i(issue_credit_o),
    .wb_valid_i    (wb_valid_o)
);

// ==== testbench/tb_exec_unit.sv ====
`timescale 1ns/1ns

module tb_exec_unit import ex_pkg::*; ();

    localparam int FIFO_DEPTH = 4;
    localparam int WB_CREDITS = 2;
    localparam int RAM_WORDS  = 64;
    localparam int RAM_BYTES  = RAM_WORDS * 4;
    localparam int N_ALU      = 60;
    localparam int N_MISC     = 20;
    localparam int N_LOADS    = 64;
    localparam int N_RAW      = 16;                 // Store/load pairs
    localparam int N_BURST    = 40;
    localparam int TOTAL_OPS  = N_ALU + N_MISC + RAM_WORDS + 32 + N_LOADS
                              + 2 * N_RAW + FIFO_DEPTH + WB_CREDITS + N_BURST;
    localparam int TIMEOUT_CYCLES = 40 * TOTAL_OPS + 200;

    typedef struct packed {
        logic      wr;
        reg_addr_t rd;
        word_t     data;
    } wb_rec_t;

    logic      clk = 1'b0;
    logic      reset;
    logic      issue_valid;
    alu_sel_t  alusel;
    alu_op_t   aluop;
    word_t     op1;
    word_t     op2;
    word_t     link_addr;
    logic      wr_flag;
    reg_addr_t regw_addr;
    word_t     mem_offset;
    logic      issue_credit;
    logic      wb_credit;
    logic      wb_valid;
    logic      wb_write;
    reg_addr_t wb_addr;
    word_t     wb_data;

    wb_rec_t    exp_q[$];
    logic [7:0] mem_model [RAM_BYTES];
    word_t      stim_state   = 32'hbef8cf68;
    word_t      credit_state = 32'hbef8cf68;
    int         issued = 0;
    int         credits_gained = 0;
    int         owed = 0;
    int         credit_delay = 0;
    bit         hold_credits = 0;
    bit         fast_credits = 0;
    int         errors = 0;
    int         checked = 0;
    int         received = 0;
    int         cycles = 0;
    int         chk0;
    int         err0;
    int         iss0;
    int         rec0;

    exec_unit #(
        .FIFO_DEPTH(FIFO_DEPTH),
        .WB_CREDITS(WB_CREDITS),
        .RAM_WORDS (RAM_WORDS)
    ) exec_unit_i (
        .clk           (clk),
        .reset         (reset),
        .issue_valid_i (issue_valid),
        .alusel_i      (alusel),
        .aluop_i       (aluop),
        .op1_i         (op1),
        .op2_i         (op2),
        .link_addr_i   (link_addr),
        .write_i       (wr_flag),
        .regw_addr_i   (regw_addr),
        .mem_offset_i  (mem_offset),
        .issue_credit_o(issue_credit),
        .wb_credit_i   (wb_credit),
        .wb_valid_o    (wb_valid),
        .wb_write_o    (wb_write),
        .wb_addr_o     (wb_addr),
        .wb_data_o     (wb_data)
    );

    always #10 clk = ~clk;

    function automatic int unsigned rnd(inout word_t state, input int unsigned n);
        state = state * 32'd1664525 + 32'd1013904223;
        return (state >> 16) % n;                   // Upper bits only
    endfunction

    function automatic word_t rand_word();
        word_t hi;
        word_t lo;
        hi = rnd(stim_state, 65536);
        lo = rnd(stim_state, 65536);
        return {hi[15:0], lo[15:0]};
    endfunction

    function automatic int avail();
        return FIFO_DEPTH + credits_gained - issued;
    endfunction

    // Expected record; stores update the byte model in issue order
    function automatic wb_rec_t ref_record(input alu_sel_t sel, input alu_op_t op,
            input word_t a, input word_t b, input word_t link, input logic wr,
            input reg_addr_t rd, input word_t off);
        wb_rec_t r;
        word_t   ea;
        word_t   v;
        int      len;
        int      base;
        r.wr   = wr;
        r.rd   = rd;
        r.data = '0;
        ea     = a + off;
        case (sel)
            SEL_LOGIC: r.data = (op == 0) ? (a | b) : (op == 1) ? (a & b)
                              : (op == 2) ? (a ^ b) : '0;
            SEL_SHIFT: r.data = (op == 0) ? (a << b[4:0]) : (op == 1) ? (a >> b[4:0])
                              : (op == 2) ? word_t'($signed(a) >>> b[4:0]) : '0;
            SEL_ARITH: begin
                case (op)
                    0: r.data = a + b;
                    1: r.data = a - b;
                    2: r.data = word_t'($signed(a) < $signed(b));
                    3: r.data = word_t'(a < b);
                    default: r.data = '0;
                endcase
            end
            SEL_LINK: r.data = link;
            SEL_MEM: begin
                len  = (op == 0 || op == 3 || op == 5) ? 1
                     : (op == 1 || op == 4 || op == 6) ? 2 : 4;
                base = int'(ea % RAM_BYTES);
                base = base - base % len;           // Low bits inside the size are ignored
                if (op >= 5) begin
                    r.wr   = 1'b0;
                    r.data = ea;
                    for (int i = 0; i < len; i++) begin
                        mem_model[base + i] = b[8*i +: 8];
                    end
                end else begin
                    v = '0;
                    for (int i = 0; i < len; i++) begin
                        v[8*i +: 8] = mem_model[base + i];
                    end
                    if (op == 0 && v[7]) v[31:8] = '1;
                    if (op == 1 && v[15]) v[31:16] = '1;
                    r.data = v;
                end
            end
            default: r.data = '0;                   // NOP and undefined selectors
        endcase
        return r;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_reg_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic issue_op(input alu_sel_t sel, input alu_op_t op, input word_t a,
            input word_t b, input word_t link, input logic wr, input reg_addr_t rd,
            input word_t off);
        @(posedge clk);
        while (avail() <= 0) begin
            issue_valid <= 1'b0;
            @(posedge clk);
        end
        issue_valid <= 1'b1;
        alusel      <= sel;
        aluop       <= op;
        op1         <= a;
        op2         <= b;
        link_addr   <= link;
        wr_flag     <= wr;
        regw_addr   <= rd;
        mem_offset  <= off;
        issued++;
        exp_q.push_back(ref_record(sel, op, a, b, link, wr, rd, off));
    endtask

    task automatic issue_random(input alu_sel_t sel, input alu_op_t op);
        word_t     a;
        word_t     b;
        word_t     link;
        word_t     off;
        logic      wr;
        reg_addr_t rd;
        a    = rand_word();
        b    = (rnd(stim_state, 8) == 0) ? a : rand_word();  // Equal operands now and then
        link = rand_word();
        off  = rand_word();
        wr   = logic'(rnd(stim_state, 2));
        rd   = reg_addr_t'(rnd(stim_state, 32));
        issue_op(sel, op, a, b, link, wr, rd, off);
    endtask

    task automatic issue_rand_alu();
        alu_sel_t sels[3] = '{SEL_LOGIC, SEL_SHIFT, SEL_ARITH};
        alu_sel_t sel;
        sel = sels[rnd(stim_state, 3)];
        issue_random(sel, alu_op_t'(rnd(stim_state, (sel == SEL_ARITH) ? 4 : 3)));
    endtask

    // Memory op with an exact effective address
    task automatic issue_mem(input alu_op_t op, input word_t ea);
        word_t a;
        word_t b;
        a = rand_word();
        b = rand_word();
        issue_op(SEL_MEM, op, a, b, rand_word(), 1'b1, reg_addr_t'(rnd(stim_state, 32)), ea - a);
    endtask

    task automatic stop_issue();
        @(posedge clk);
        issue_valid <= 1'b0;
    endtask

    task automatic begin_test();
        chk0 = checked;
        err0 = errors;
        iss0 = issued;
        rec0 = received;
    endtask

    task automatic end_test(input string name);
        while (exp_q.size() != 0 || owed != 0) @(posedge clk);
        repeat (3) @(posedge clk);
        if (received - rec0 != issued - iss0) begin
            $display("Record count wrong in %s: %0d issued, %0d received",
                     name, issued - iss0, received - rec0);
            errors++;
        end
        $display("Test %s done: %0d records, %0d errors", name, checked - chk0, errors - err0);
    endtask

    // Issue credit count and write-back compare, sampled mid-cycle
    always @(negedge clk) begin
        wb_rec_t e;
        if (!reset && issue_credit) credits_gained++;
        if (!reset && wb_valid) begin
            received++;
            owed++;
            if (exp_q.size() == 0) begin
                $display("Unexpected write-back record at %0t with nothing outstanding", $time);
                errors++;
            end else begin
                e = exp_q.pop_front();
                check_bit("wb_write_o", wb_write, e.wr);
                check_reg_addr("wb_addr_o", wb_addr, e.rd);
                check_word("wb_data_o", wb_data, e.data);
                checked++;
            end
        end
    end

    // Write-back credit return after a random delay
    always @(posedge clk) begin
        if (reset || hold_credits || owed == 0) begin
            wb_credit <= 1'b0;
        end else if (credit_delay > 0) begin
            wb_credit <= 1'b0;
            credit_delay--;
        end else begin
            wb_credit    <= 1'b1;
            owed--;
            credit_delay = fast_credits ? 0 : rnd(credit_state, 4);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d records outstanding", cycles, exp_q.size());
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        int chk_hold;
        reset       = 1'b1;
        issue_valid = 1'b0;
        alusel      = SEL_NOP;
        aluop       = '0;
        op1         = '0;
        op2         = '0;
        link_addr   = '0;
        wr_flag     = 1'b0;
        regw_addr   = '0;
        mem_offset  = '0;
        wb_credit   = 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        begin_test();
        for (int i = 0; i < N_ALU; i++) issue_rand_alu();
        stop_issue();
        end_test("logic/shift/arith");

        begin_test();
        for (int i = 0; i < N_MISC; i++) begin
            case (rnd(stim_state, 4))
                0: issue_random(SEL_LINK, alu_op_t'(rnd(stim_state, 8)));
                1: issue_random(3'b011, alu_op_t'(rnd(stim_state, 8)));
                2: issue_random(3'b101, alu_op_t'(rnd(stim_state, 8)));
                default: issue_random(SEL_NOP, alu_op_t'(rnd(stim_state, 8)));
            endcase
        end
        stop_issue();
        end_test("link/undefined");

        begin_test();
        for (int i = 0; i < RAM_WORDS; i++) begin
            issue_mem(3'd7, word_t'(i * 4 + RAM_BYTES * rnd(stim_state, 1024)));
        end
        for (int i = 0; i < 32; i++) issue_mem(alu_op_t'(5 + rnd(stim_state, 2)), rand_word());
        for (int i = 0; i < N_LOADS; i++) issue_mem(alu_op_t'(rnd(stim_state, 5)), rand_word());
        stop_issue();
        end_test("store/load lanes");

        begin_test();
        for (int i = 0; i < N_RAW; i++) begin
            word_t ea;
            ea = rand_word();
            issue_mem(alu_op_t'(5 + rnd(stim_state, 3)), ea);
            issue_mem(alu_op_t'(rnd(stim_state, 5)), ea);
        end
        stop_issue();
        end_test("store then load");

        begin_test();
        @(negedge clk);
        hold_credits = 1'b1;
        chk_hold = checked;
        repeat (2) begin
            while (avail() > 0) issue_rand_alu();
            stop_issue();
            repeat (20) @(posedge clk);
        end
        if (checked - chk_hold != WB_CREDITS || exp_q.size() != FIFO_DEPTH || avail() != 0) begin
            $display("Credit stall failed: %0d records while held, %0d queued, %0d credits left",
                     checked - chk_hold, exp_q.size(), avail());
            errors++;
        end
        @(negedge clk);
        hold_credits = 1'b0;
        end_test("credit back-pressure");

        begin_test();
        @(negedge clk);
        fast_credits = 1'b1;
        for (int i = 0; i < N_BURST; i++) issue_rand_alu();
        stop_issue();
        end_test("full-rate burst");

        errors += exec_unit_i.exec_checker_i.fail_count;
        $display("Summary: %0d records checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
verilog/ex_pkg.sv
verilog/data_ram.sv
verilog/issue_fifo.sv
verilog/stage_ex.sv
verilog/stage_mem.sv
verilog/exec_unit.sv
testbench/exec_unit_checker.sv
testbench/tb_exec_unit.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the exec_unit testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module tb_exec_unit -o tb_exec_unit &&
./obj_dir/tb_exec_unit | tee /dev/stderr | grep "TEST RESULT: PASS" > /dev/null &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
